//--- include/accel_cfg_consts.svh
`ifndef ACCEL_CFG_CONSTS_SVH
`define ACCEL_CFG_CONSTS_SVH

// Configuration registers per region
`define CFG_N_CON 3
`define CFG_N_ACT 4
`define CFG_N_WEI 3
`define CFG_N_OUT 4

`define CFG_N_REGS (`CFG_N_CON + `CFG_N_ACT + `CFG_N_WEI + `CFG_N_OUT)
// Two interrupt enables follow the region registers
`define CFG_N_WRITES (`CFG_N_REGS + 2)

// Region base byte offsets
`define CFG_BASE_CON 'h010
`define CFG_BASE_ACT 'h100
`define CFG_BASE_WEI 'h200
`define CFG_BASE_OUT 'h300

`define CFG_OFF_CONTROL 'h000
`define CFG_OFF_INT_EN 'h004
`define CFG_OFF_INT_STATUS 'h00C

`define CFG_ADDR_W 13

// Argument block layout
`define ARG_N_WORDS 15
`define ARG_IDX_MODE 0
`define ARG_IDX_CFG 1
`define CFG_IDX_W 5

`endif

//--- hdl/accel_cfg_pkg.sv
package accel_cfg_pkg;

    typedef enum logic [2:0] {
        MAIN_FSM,
        LFMAP_FEEDER,
        WEIGHT_FEEDER,
        PS_MANAGER,
        INTERRUPTS
    } cfg_region_e;

    // Mode word from the host argument block
    typedef struct packed {
        logic [8:0]  rsvd_hi;
        logic        skip_compute;
        logic        keep_c;
        logic        keep_b;
        logic        keep_a;
        logic [18:0] rsvd_lo;
    } mode_word_t;

    // Control register command word
    typedef struct packed {
        logic [11:0] zero_hi;
        logic        keep_c;
        logic        keep_b;
        logic        keep_a;
        logic        buf_swap;
        logic [13:0] zero_mid;
        logic        enable;
        logic        start;
    } start_cmd_t;

    typedef union packed {
        logic [31:0] raw;
        start_cmd_t  cmd;
    } wdata_u;

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } axil_wr_rsp_t;

endpackage

//--- hdl/cfg_arg_latch.sv
`timescale 1ns/1ns

`include "accel_cfg_consts.svh"

module cfg_arg_latch import accel_cfg_pkg::*; (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               latch,
    input  logic [`ARG_N_WORDS-1:0][31:0]      arg_words,
    input  logic [`CFG_IDX_W-1:0]              cfg_idx,
    output mode_word_t                         mode,
    output logic [31:0]                        cfg_word
);

    logic [`CFG_N_REGS-1:0][31:0] cfg_regs;

    // Mode word steers the sequencer, so it starts from a known value
    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= '0;
        end else if (latch) begin
            mode <= mode_word_t'(arg_words[`ARG_IDX_MODE]);
        end
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            for (int i = 0; i < `CFG_N_REGS; i++) begin
                cfg_regs[i] <= arg_words[`ARG_IDX_CFG + i];
            end
        end
    end

    // Indexes past the region registers are the interrupt enables
    always_comb begin
        if (cfg_idx < `CFG_IDX_W'(`CFG_N_REGS)) begin
            cfg_word = cfg_regs[cfg_idx];
        end else begin
            cfg_word = 32'h1;
        end
    end

endmodule

//--- hdl/cfg_addr_walker.sv
`timescale 1ns/1ns

`include "accel_cfg_consts.svh"

module cfg_addr_walker import accel_cfg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    burst_load,
    input  logic                    wr_accept,
    output logic [`CFG_ADDR_W-1:0]  cfg_addr,
    output logic [`CFG_IDX_W-1:0]   cfg_idx,
    output cfg_region_e             cfg_region,
    output logic                    burst_last
);

    logic       active;
    // Writes left in the current region, minus one
    logic [2:0] rem;

    assign burst_last = active && (cfg_region == INTERRUPTS) && (rem == 3'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            cfg_addr   <= '0;
            cfg_idx    <= '0;
            cfg_region <= MAIN_FSM;
            rem        <= '0;
        end else if (burst_load) begin
            active     <= 1'b1;
            cfg_addr   <= `CFG_ADDR_W'(`CFG_BASE_CON);
            cfg_idx    <= '0;
            cfg_region <= MAIN_FSM;
            rem        <= 3'(`CFG_N_CON - 1);
        end else if (active && wr_accept) begin
            cfg_idx <= cfg_idx + 1'b1;
            if (rem != 3'd0) begin
                cfg_addr <= cfg_addr + `CFG_ADDR_W'(4);
                rem      <= rem - 3'd1;
            end else begin
                // Jump to the next region base
                case (cfg_region)
                    MAIN_FSM: begin
                        cfg_addr   <= `CFG_ADDR_W'(`CFG_BASE_ACT);
                        cfg_region <= LFMAP_FEEDER;
                        rem        <= 3'(`CFG_N_ACT - 1);
                    end
                    LFMAP_FEEDER: begin
                        cfg_addr   <= `CFG_ADDR_W'(`CFG_BASE_WEI);
                        cfg_region <= WEIGHT_FEEDER;
                        rem        <= 3'(`CFG_N_WEI - 1);
                    end
                    WEIGHT_FEEDER: begin
                        cfg_addr   <= `CFG_ADDR_W'(`CFG_BASE_OUT);
                        cfg_region <= PS_MANAGER;
                        rem        <= 3'(`CFG_N_OUT - 1);
                    end
                    PS_MANAGER: begin
                        cfg_addr   <= `CFG_ADDR_W'(`CFG_OFF_INT_EN);
                        cfg_region <= INTERRUPTS;
                        rem        <= 3'd1;
                    end
                    default: begin
                        active <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/axil_write_port.sv
`timescale 1ns/1ns

`include "accel_cfg_consts.svh"

module axil_write_port import accel_cfg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_req,
    input  logic [`CFG_ADDR_W-1:0]  wr_addr,
    input  wdata_u                  wr_data,
    input  axil_wr_rsp_t            rsp,
    input  logic                    bready,
    output axil_wr_req_t            axil_req,
    output logic                    wr_accept
);

    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;

    // Each channel drops its valid once its own handshake is done
    assign axil_req.awvalid = wr_req && !aw_done;
    assign axil_req.wvalid  = wr_req && !w_done;
    assign axil_req.awaddr  = {{(32 - `CFG_ADDR_W){1'b0}}, wr_addr};
    assign axil_req.wdata   = wr_data.raw;
    assign axil_req.wstrb   = 4'hF;
    assign axil_req.bready  = bready;

    assign aw_hs = axil_req.awvalid && rsp.awready;
    assign w_hs  = axil_req.wvalid && rsp.wready;

    // Pair is complete when both phases are done, now or earlier
    assign wr_accept = wr_req && (aw_done || aw_hs) && (w_done || w_hs);

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (wr_accept) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_done <= 1'b1;
            end
            if (w_hs) begin
                w_done <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/wresp_tracker.sv
`timescale 1ns/1ns

`include "accel_cfg_consts.svh"

module wresp_tracker (
    input  logic clk,
    input  logic rst,
    input  logic burst_load,
    input  logic single_wait,
    input  logic bvalid,
    output logic bready,
    output logic burst_resp_done
);

    logic                  counting;
    logic [`CFG_IDX_W-1:0] resp_cnt;

    assign bready = counting || single_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            counting        <= 1'b0;
            resp_cnt        <= '0;
            burst_resp_done <= 1'b0;
        end else if (burst_load) begin
            counting        <= 1'b1;
            resp_cnt        <= '0;
            burst_resp_done <= 1'b0;
        end else if (counting && bvalid) begin
            resp_cnt <= resp_cnt + 1'b1;
            // Last response of the burst
            if (resp_cnt == `CFG_IDX_W'(`CFG_N_WRITES - 1)) begin
                counting        <= 1'b0;
                burst_resp_done <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/cfg_sequencer.sv
`timescale 1ns/1ns

`include "accel_cfg_consts.svh"

module cfg_sequencer import accel_cfg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fsm_start,
    input  logic                    sauria_irq,
    input  mode_word_t              mode,
    input  logic [`CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [31:0]             cfg_word,
    input  logic                    burst_last,
    input  logic                    wr_accept,
    input  logic                    burst_resp_done,
    output logic                    latch,
    output logic                    burst_load,
    output logic                    wr_req,
    output logic [`CFG_ADDR_W-1:0]  wr_addr,
    output wdata_u                  wr_data,
    output logic                    single_wait,
    input  logic                    bvalid,
    output logic                    fsm_done,
    output logic                    fwd_irq
);

    typedef enum logic [3:0] {
        IDLE,
        READ_ARGS,
        SEND_CFG,
        SYNC_WRESP,
        SEND_START,
        WAIT_START_WRESP,
        WAIT_ACC_FINISH,
        SEND_CLR_INTR,
        WAIT_CLR_WRESP,
        FINISH
    } state_e;

    state_e     state;
    start_cmd_t start_cmd;

    assign latch       = (state == READ_ARGS);
    assign burst_load  = (state == READ_ARGS);
    assign wr_req      = (state == SEND_CFG) || (state == SEND_START) ||
                         (state == SEND_CLR_INTR);
    assign single_wait = (state == WAIT_START_WRESP) || (state == WAIT_CLR_WRESP);
    assign fsm_done    = (state == FINISH);
    assign fwd_irq     = (state == IDLE) && sauria_irq;

    // Stand-alone start command
    always_comb begin
        start_cmd          = '0;
        start_cmd.start    = !mode.skip_compute;
        start_cmd.enable   = 1'b1;
        start_cmd.buf_swap = 1'b1;
        start_cmd.keep_a   = mode.keep_a;
        start_cmd.keep_b   = mode.keep_b;
        start_cmd.keep_c   = mode.keep_c;
    end

    always_comb begin
        wr_addr     = cfg_addr;
        wr_data.raw = cfg_word;
        case (state)
            SEND_START: begin
                wr_addr     = `CFG_ADDR_W'(`CFG_OFF_CONTROL);
                wr_data.cmd = start_cmd;
            end
            SEND_CLR_INTR: begin
                wr_addr     = `CFG_ADDR_W'(`CFG_OFF_INT_STATUS);
                wr_data.raw = 32'h1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (fsm_start) state <= READ_ARGS;
                READ_ARGS: state <= SEND_CFG;
                SEND_CFG: if (wr_accept && burst_last) state <= SYNC_WRESP;
                // Control write waits for the whole burst to be acknowledged
                SYNC_WRESP: if (burst_resp_done) state <= SEND_START;
                SEND_START: if (wr_accept) state <= WAIT_START_WRESP;
                WAIT_START_WRESP: begin
                    if (bvalid) begin
                        state <= start_cmd.start ? WAIT_ACC_FINISH : FINISH;
                    end
                end
                WAIT_ACC_FINISH: if (sauria_irq) state <= SEND_CLR_INTR;
                SEND_CLR_INTR: if (wr_accept) state <= WAIT_CLR_WRESP;
                WAIT_CLR_WRESP: if (bvalid) state <= FINISH;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/accel_cfg_ctrl.sv
`timescale 1ns/1ns

`include "accel_cfg_consts.svh"

module accel_cfg_ctrl import accel_cfg_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fsm_start,
    input  logic [`ARG_N_WORDS-1:0][31:0]  arg_words,
    input  logic                           sauria_irq,
    input  axil_wr_rsp_t                   axil_rsp,
    output axil_wr_req_t                   axil_req,
    output logic                           fsm_done,
    output logic                           fwd_irq
);

    logic                   latch;
    logic                   burst_load;
    mode_word_t             mode;
    logic [31:0]            cfg_word;
    logic [`CFG_ADDR_W-1:0] cfg_addr;
    logic [`CFG_IDX_W-1:0]  cfg_idx;
    cfg_region_e            cfg_region;
    logic                   burst_last;
    logic                   wr_req;
    logic [`CFG_ADDR_W-1:0] wr_addr;
    wdata_u                 wr_data;
    logic                   wr_accept;
    logic                   single_wait;
    logic                   bready;
    logic                   burst_resp_done;

    cfg_arg_latch u_arg_latch (
        .clk(clk), .rst(rst), .latch(latch), .arg_words(arg_words),
        .cfg_idx(cfg_idx), .mode(mode), .cfg_word(cfg_word)
    );

    cfg_addr_walker u_addr_walker (
        .clk(clk), .rst(rst), .burst_load(burst_load), .wr_accept(wr_accept),
        .cfg_addr(cfg_addr), .cfg_idx(cfg_idx), .cfg_region(cfg_region),
        .burst_last(burst_last)
    );

    axil_write_port u_write_port (
        .clk(clk), .rst(rst), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .rsp(axil_rsp), .bready(bready), .axil_req(axil_req), .wr_accept(wr_accept)
    );

    wresp_tracker u_wresp_tracker (
        .clk(clk), .rst(rst), .burst_load(burst_load), .single_wait(single_wait),
        .bvalid(axil_rsp.bvalid), .bready(bready), .burst_resp_done(burst_resp_done)
    );

    cfg_sequencer u_sequencer (
        .clk(clk), .rst(rst), .fsm_start(fsm_start), .sauria_irq(sauria_irq),
        .mode(mode), .cfg_addr(cfg_addr), .cfg_word(cfg_word), .burst_last(burst_last),
        .wr_accept(wr_accept), .burst_resp_done(burst_resp_done), .latch(latch),
        .burst_load(burst_load), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .single_wait(single_wait), .bvalid(axil_rsp.bvalid), .fsm_done(fsm_done),
        .fwd_irq(fwd_irq)
    );

endmodule

//--- testbench/accel_cfg_ctrl_assert.sv
`timescale 1ns/1ns

module accel_cfg_ctrl_assert import accel_cfg_pkg::*; (
    input logic         clk,
    input logic         rst,
    input axil_wr_req_t axil_req,
    input axil_wr_rsp_t axil_rsp,
    input logic         fsm_done
);

    // Stalled address phase keeps valid and address
    property aw_hold;
        @(posedge clk) disable iff (rst)
            axil_req.awvalid && !axil_rsp.awready |=>
                axil_req.awvalid && $stable(axil_req.awaddr);
    endproperty

    // Stalled data phase keeps valid and data
    property w_hold;
        @(posedge clk) disable iff (rst)
            axil_req.wvalid && !axil_rsp.wready |=>
                axil_req.wvalid && $stable(axil_req.wdata);
    endproperty

    property reset_quiet;
        @(posedge clk) rst && $past(rst) |->
            !axil_req.awvalid && !axil_req.wvalid && !axil_req.bready && !fsm_done;
    endproperty

    assert property (aw_hold) else $error("awaddr changed while waiting for awready");
    assert property (w_hold) else $error("wdata changed while waiting for wready");
    assert property (reset_quiet) else $error("outputs active during reset");

endmodule

bind accel_cfg_ctrl accel_cfg_ctrl_assert u_assert (
    .clk(clk), .rst(rst), .axil_req(axil_req), .axil_rsp(axil_rsp), .fsm_done(fsm_done)
);

//--- testbench/accel_cfg_ctrl_tb.sv
`timescale 1ns/1ns

`include "accel_cfg_consts.svh"

module accel_cfg_ctrl_tb import accel_cfg_pkg::*; ();

    localparam int N_TESTS = 4;
    // Record per test: arguments, irq flag, control word
    localparam int REC_W = `ARG_N_WORDS + 2;
    localparam int TIMEOUT = N_TESTS * 200;

    logic                          clk;
    logic                          rst = 1'b1;
    logic                          fsm_start = 1'b0;
    logic [`ARG_N_WORDS-1:0][31:0] arg_words = '0;
    logic                          sauria_irq = 1'b0;
    axil_wr_rsp_t                  axil_rsp = '0;
    axil_wr_req_t                  axil_req;
    logic                          fsm_done;
    logic                          fwd_irq;

    logic [31:0] tdata [N_TESTS * REC_W];
    logic [31:0] exp_addr [`CFG_N_WRITES + 2];
    logic [31:0] exp_data [`CFG_N_WRITES + 2];
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [`ARG_N_WORDS-1:0][31:0] args_cur = '0;
    integer seed = 32'hd9d5ac4e;
    int exp_n = 0;
    int exp_pos = 0;
    int resp_cnt = 0;
    int pend = 0;
    int b_wait = 0;
    int acc_wait = 0;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    logic start_req = 1'b0;
    logic b_fire = 1'b0;
    logic acc_irq = 1'b0;
    logic idle_irq = 1'b0;
    logic clr_seen = 1'b0;
    logic running = 1'b0;
    logic done_seen = 1'b0;

    accel_cfg_ctrl uut (
        .clk(clk), .rst(rst), .fsm_start(fsm_start), .arg_words(arg_words),
        .sauria_irq(sauria_irq), .axil_rsp(axil_rsp), .axil_req(axil_req),
        .fsm_done(fsm_done), .fwd_irq(fwd_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d errors so far", cycles, errors);
        $display("Errors found");
        $finish;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    // Expected write list from the register map and the mode word
    task automatic build_expected(input int t);
        int base [4];
        int cnt [4];
        int n;
        logic [31:0] mode;
        logic [31:0] cmd;
        base = '{`CFG_BASE_CON, `CFG_BASE_ACT, `CFG_BASE_WEI, `CFG_BASE_OUT};
        cnt = '{`CFG_N_CON, `CFG_N_ACT, `CFG_N_WEI, `CFG_N_OUT};
        for (int k = 0; k < `ARG_N_WORDS; k++) begin
            args_cur[k] = tdata[t * REC_W + k];
        end
        mode = args_cur[0];
        n = 0;
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < cnt[r]; i++) begin
                exp_addr[n] = base[r] + 4 * i;
                exp_data[n] = args_cur[1 + n];
                n++;
            end
        end
        for (int i = 0; i < 2; i++) begin
            exp_addr[n] = `CFG_OFF_INT_EN + 4 * i;
            exp_data[n] = 32'h1;
            n++;
        end
        // Start is the inverse of skip_compute, keep bits move down by two
        cmd = '0;
        cmd[0] = !mode[22];
        cmd[1] = 1'b1;
        cmd[16] = 1'b1;
        cmd[19:17] = mode[21:19];
        exp_addr[n] = `CFG_OFF_CONTROL;
        exp_data[n] = cmd;
        n++;
        if (cmd[0]) begin
            exp_addr[n] = `CFG_OFF_INT_STATUS;
            exp_data[n] = 32'h1;
            n++;
        end
        exp_n = n;
        compare_word("testdata control word", cmd, tdata[t * REC_W + `ARG_N_WORDS + 1]);
        compare_word("testdata irq flag", {31'b0, cmd[0]}, tdata[t * REC_W + `ARG_N_WORDS]);
    endtask

    // Slave side, driven on the rising edge
    task automatic drive_slave();
        fsm_start <= start_req;
        start_req = 1'b0;
        arg_words <= args_cur;
        axil_rsp.awready <= ($random(seed) % 4) != 0;
        axil_rsp.wready <= ($random(seed) % 4) != 0;
        if (axil_rsp.bvalid) begin
            if (b_fire) begin
                axil_rsp.bvalid <= 1'b0;
                b_wait = $unsigned($random(seed)) % 4;
            end
        end else if (pend > 0) begin
            if (b_wait == 0) axil_rsp.bvalid <= 1'b1;
            else b_wait--;
        end
        if (acc_wait > 0) begin
            acc_wait--;
            if (acc_wait == 0) acc_irq = 1'b1;
        end
        if (clr_seen) begin
            acc_irq = 1'b0;
            clr_seen = 1'b0;
        end
        sauria_irq <= acc_irq || idle_irq;
    endtask

    task automatic check_write(input logic [31:0] addr, input logic [31:0] data);
        if (exp_pos >= exp_n) begin
            flag_error($sformatf("Unexpected write to %h after the sequence", addr));
        end else begin
            compare_word("awaddr", exp_addr[exp_pos], addr);
            compare_word("wdata", exp_data[exp_pos], data);
        end
        exp_pos++;
        pend++;
        if (addr == `CFG_OFF_CONTROL && resp_cnt < `CFG_N_WRITES) begin
            flag_error("Control write issued before all burst responses came back");
        end
        if (acc_wait > 0) begin
            flag_error("Write issued while waiting for the accelerator interrupt");
        end
        // Accelerator raises its interrupt some cycles after a real start
        if (addr == `CFG_OFF_CONTROL && data[0]) begin
            acc_wait = 5 + $unsigned($random(seed)) % 16;
        end
        if (addr == `CFG_OFF_INT_STATUS) clr_seen = 1'b1;
    endtask

    // Sampled on the falling edge, when all outputs are settled
    task automatic monitor();
        logic aw_fire;
        logic w_fire;
        aw_fire = axil_req.awvalid && axil_rsp.awready;
        w_fire = axil_req.wvalid && axil_rsp.wready;
        b_fire = axil_rsp.bvalid && axil_req.bready;
        if (aw_fire) addr_q.push_back(axil_req.awaddr);
        if (w_fire) begin
            data_q.push_back(axil_req.wdata);
            compare_word("wstrb", 32'hF, {28'b0, axil_req.wstrb});
        end
        if (addr_q.size() > 0 && data_q.size() > 0) begin
            check_write(addr_q.pop_front(), data_q.pop_front());
        end
        if (b_fire) begin
            resp_cnt++;
            pend--;
        end
        checks++;
        if (running && fwd_irq) flag_error("fwd_irq high while a sequence runs");
        if (!running) compare_word("fwd_irq", {31'b0, sauria_irq}, {31'b0, fwd_irq});
        if (fsm_done) begin
            if (!running) flag_error("fsm_done pulsed while idle");
            else done_seen = 1'b1;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        drive_slave();
        @(negedge clk);
        monitor();
    endtask

    task automatic run_test(input int t);
        build_expected(t);
        resp_cnt = 0;
        exp_pos = 0;
        done_seen = 1'b0;
        start_req = 1'b1;
        tick();
        running = 1'b1;
        while (!done_seen) tick();
        running = 1'b0;
        checks++;
        if (exp_pos != exp_n) begin
            flag_error($sformatf("Test %0d ended after %0d of %0d writes", t, exp_pos, exp_n));
        end
        // Interrupt forwarding while idle
        idle_irq = 1'b1;
        repeat (3) tick();
        idle_irq = 1'b0;
        repeat (2) tick();
    endtask

    initial begin
        $readmemh("testbench/accel_cfg_testdata.txt", tdata);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- accel_cfg_ctrl.f
+incdir+include
hdl/accel_cfg_pkg.sv
hdl/cfg_arg_latch.sv
hdl/cfg_addr_walker.sv
hdl/axil_write_port.sv
hdl/wresp_tracker.sv
hdl/cfg_sequencer.sv
hdl/accel_cfg_ctrl.sv
testbench/accel_cfg_ctrl_assert.sv
testbench/accel_cfg_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module accel_cfg_ctrl_tb -f accel_cfg_ctrl.f \
    -o accel_cfg_ctrl_sim &&
./obj_dir/accel_cfg_ctrl_sim | tee sim.log &&
grep -qx "No errors" sim.log || { echo "Simulation failed"; exit 1; }

//--- testbench/accel_cfg_testdata.txt
// Per test: mode word and config words 1 to 7, then config words 8 to 14,
// then the irq flag and the expected control word
00080000 A0000001 A0000002 A0000003 B0000011 B0000012 B0000013 B0000014
C0000021 C0000022 C0000023 D0000031 D0000032 D0000033 D0000034
1 00030003
00500000 12345678 9ABCDEF0 0F1E2D3C 4B5A6978 87A5C3E1 DEADBEEF CAFEF00D
0BADC0DE FFFFFFFF 00000000 13579BDF 2468ACE0 55AA55AA AA55AA55
0 00050002
00380000 00000001 00000002 00000004 00000008 00000010 00000020 00000040
00000080 00000100 00000200 00000400 00000800 00001000 00002000
1 000F0003
FFFFFFFF 7FFFFFFF 3FFFFFFF 1FFFFFFF 0FFFFFFF 07FFFFFF 03FFFFFF 01FFFFFF
00FFFFFF 007FFFFF 003FFFFF 001FFFFF 000FFFFF 0007FFFF 0003FFFF
0 000F0002
